// ==== files.f ====
+incdir+.
prc_pkg.sv
prc_regs.sv
prc_frame_timer.sv
prc_stage_ctrl.sv
prc_map_draw.sv
prc_frame_copy.sv
prc.sv
tb_prc.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -j 0 --top-module tb_prc -f files.f -o tb_prc

./obj_dir/tb_prc > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation failed" sim.log; then
    exit 1
fi
if ! grep -q "Simulation completed successfully" sim.log; then
    exit 1
fi
exit 0

// ==== prc_tb_tasks.svh ====
`ifndef PRC_TB_TASKS_SVH
`define PRC_TB_TASKS_SVH

task automatic check_value(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
    if (expected !== actual)
    begin
        $display("FAIL %s expected %0h actual %0h", name, expected, actual);
        $display("Simulation failed");
        $fatal(1, "mismatch in %s", name);
    end
endtask

task automatic reg_write(input logic [23:0] addr, input logic [7:0] data);
    @(posedge clk);
    bus_address_in <= addr;
    host_data      <= data;
    bus_write      <= 1'b1;
    @(posedge clk);
    bus_write <= 1'b0;
endtask

task automatic reg_read(input logic [23:0] addr, output logic [7:0] data);
    @(posedge clk);
    bus_address_in <= addr;
    @(posedge clk);
    data = bus_data_out;     // readback mux while the bus is not granted
endtask

task automatic expect_reg(input string name, input logic [23:0] addr,
                          input logic [7:0] data, input logic [7:0] expected);
    logic [7:0] value;
    reg_write(addr, data);
    reg_read(addr, value);
    check_value(name, 32'(expected), 32'(value));
endtask

function automatic int frames_per_render(input logic [2:0] sel);
    case (sel)
        3'd0:    return 3;
        3'd1:    return 6;
        3'd2:    return 9;
        3'd3:    return 12;
        3'd4:    return 2;
        3'd5:    return 4;
        3'd6:    return 6;
        default: return 8;
    endcase
endfunction

// byte pattern from the full address
function automatic logic [7:0] fill_byte(input int addr);
    return 8'(addr) ^ 8'(addr >> 8) ^ 8'h5A;
endfunction

task automatic wait_render_done();
    @(posedge clk);
    while (!irq_render_done)
        @(posedge clk);
endtask

// enable the engines for one active frame, then switch them off again
task automatic render_once(input logic [7:0] mode);
    reg_write(`PRC_REG_MODE, mode);
    @(posedge clk);
    while (!irq_copy_complete)
        @(posedge clk);
    check_value("bus_request_held", 32'd1, 32'(bus_request));
    wait_render_done();
    check_value("bus_request_released", 32'd0, 32'(bus_request));
    reg_write(`PRC_REG_MODE, mode & 8'hF5);
endtask

task automatic compare_vram(input string name);
    for (int i = 0; i < 768; i++)
        check_value($sformatf("%s_vram_%0d", name, i), 32'(exp_vram[10'(i)]),
                    32'(mem[16'(`PRC_VRAM_BASE + i)]));
endtask

task automatic compare_lcd_stream(input string name, input int start);
    int idx;
    check_value({name, "_lcd_len"}, 32'(start + 8 * 99), 32'(lcd_q.size()));
    idx = start;
    for (int p = 0; p < 8; p++)
    begin
        check_value($sformatf("%s_cmd_hi_p%0d", name, p), 32'({1'b0, 8'h10}), 32'(lcd_q[idx]));
        check_value($sformatf("%s_cmd_lo_p%0d", name, p), 32'({1'b0, 8'h00}),
                    32'(lcd_q[idx + 1]));
        check_value($sformatf("%s_cmd_page_p%0d", name, p), 32'({1'b0, 8'hB0 + 8'(p)}),
                    32'(lcd_q[idx + 2]));
        idx = idx + 3;
        for (int c = 0; c < 96; c++)
        begin
            check_value($sformatf("%s_lcd_p%0d_c%0d", name, p, c),
                        32'({1'b1, exp_vram[10'(p * 96 + c)]}), 32'(lcd_q[idx]));
            idx++;
        end
    end
endtask

task automatic register_access();
    logic [7:0] value;
    expect_reg("reg_mode", `PRC_REG_MODE, 8'hF5, 8'h35);     // engines stay off
    expect_reg("reg_map_lo", `PRC_REG_MAP_LO, 8'hFF, 8'hF8);
    expect_reg("reg_map_mid", `PRC_REG_MAP_MID, 8'hA6, 8'hA6);
    expect_reg("reg_map_hi", `PRC_REG_MAP_HI, 8'hFF, 8'h1F);
    expect_reg("reg_spr_lo", `PRC_REG_SPR_LO, 8'hFF, 8'hC0);
    expect_reg("reg_spr_mid", `PRC_REG_SPR_MID, 8'h5C, 8'h5C);
    expect_reg("reg_spr_hi", `PRC_REG_SPR_HI, 8'hE3, 8'h03);
    reg_write(`PRC_REG_RATE, 8'h0B);
    reg_read(`PRC_REG_RATE, value);
    check_value("reg_rate", 32'hB, 32'(value[3:0]));     // upper nibble is the frame count
    reg_read(`PRC_REG_COUNTER, value);
    check_value("reg_counter", 32'd1, 32'(value >= 8'd1 && value <= 8'h42));
    expect_reg("reg_unmapped_208b", 24'h00208B, 8'hFF, 8'h00);
    expect_reg("reg_unmapped_20fe", `PRC_LCD_CMD, 8'h77, 8'h00);
    reg_write(`PRC_REG_MODE, 8'h00);
endtask

task automatic scroll_limits();
    reg_write(`PRC_REG_MODE, 8'h00);    // 12x16 tiles, x limit 0, y limit 64
    expect_reg("scroll_y_max", `PRC_REG_SCROLL_Y, 8'd64, 8'd64);
    expect_reg("scroll_y_over", `PRC_REG_SCROLL_Y, 8'd65, 8'd64);
    expect_reg("scroll_x_over", `PRC_REG_SCROLL_X, 8'd1, 8'd0);
    reg_write(`PRC_REG_MODE, 8'h20);    // 24x8 tiles, x limit 96, y limit 0
    expect_reg("scroll_x_max", `PRC_REG_SCROLL_X, 8'd96, 8'd96);
    expect_reg("scroll_x_over_wide", `PRC_REG_SCROLL_X, 8'd97, 8'd96);
    expect_reg("scroll_y_over_flat", `PRC_REG_SCROLL_Y, 8'd1, 8'd64);
    expect_reg("scroll_y_zero", `PRC_REG_SCROLL_Y, 8'd0, 8'd0);
    expect_reg("scroll_x_zero", `PRC_REG_SCROLL_X, 8'd0, 8'd0);
    reg_write(`PRC_REG_MODE, 8'h00);
endtask

task automatic render_rate(input logic [2:0] sel);
    int start;
    reg_write(`PRC_REG_RATE, {4'd0, sel, 1'b0});
    wait_render_done();         // first period after a rate change is short
    start = cycle;
    wait_render_done();
    check_value($sformatf("rate_sel_%0d", sel), 32'(frames_per_render(sel) * frame_cycles),
                32'(cycle - start));
endtask

task automatic frame_copy_only();
    int lcd_start;
    int irq_start;
    for (int i = 0; i < 768; i++)
    begin
        exp_vram[10'(i)] = fill_byte(`PRC_VRAM_BASE + i);
        mem[16'(`PRC_VRAM_BASE + i)] = exp_vram[10'(i)];
    end
    lcd_start = lcd_q.size();
    irq_start = copy_irqs;
    reg_write(`PRC_REG_RATE, 8'h08);    // render every second frame
    render_once(8'h08);
    compare_lcd_stream("frame_copy", lcd_start);
    compare_vram("frame_copy");
    check_value("copy_irq_count", 32'd1, 32'(copy_irqs - irq_start));
endtask

task automatic map_draw_and_copy(input string name, input logic bp);
    int lcd_start;
    int stall_start;
    int sx;
    int sy;
    int mx;
    int my;
    int tile;
    sx = 1 + int'($urandom % 96);       // 24x16 map allows 96 and 64
    sy = 1 + int'($urandom % 64);
    for (int i = 0; i < 24 * 16; i++)
        mem[16'(`PRC_TILEMAP_BASE + i)] = 8'($urandom);
    for (int i = 0; i < 2048; i++)
        mem[16'(32'h4000 + i)] = 8'($urandom);   // tile patterns at map base 0x4000
    for (int i = 0; i < 768; i++)
        mem[16'(`PRC_VRAM_BASE + i)] = 8'h00;
    for (int p = 0; p < 8; p++)
    begin
        for (int c = 0; c < 96; c++)
        begin
            mx   = c + sx;
            my   = p * 8 + sy;
            tile = int'(mem[16'(`PRC_TILEMAP_BASE + (my / 8) * 24 + mx / 8)]);
            exp_vram[10'(p * 96 + c)] = mem[16'(32'h4000 + tile * 8 + mx % 8)] >> (my % 8);
        end
    end

    reg_write(`PRC_REG_MODE, 8'h30);
    reg_write(`PRC_REG_SCROLL_X, 8'(sx));
    reg_write(`PRC_REG_SCROLL_Y, 8'(sy));
    reg_write(`PRC_REG_MAP_LO, 8'h00);
    reg_write(`PRC_REG_MAP_MID, 8'h40);
    reg_write(`PRC_REG_MAP_HI, 8'h00);
    drop_ack    = bp;
    lcd_start   = lcd_q.size();
    stall_start = stall_cycles;
    render_once(8'h3A);
    drop_ack = 1'b0;

    compare_vram(name);
    compare_lcd_stream(name, lcd_start);
    if (bp)
        check_value({name, "_stalls"}, 32'd1, 32'(stall_cycles - stall_start > 100));
endtask

`endif

// ==== tb_prc.sv ====
`include "prc_defines.svh"

module tb_prc;

timeunit 1ns;
timeprecision 1ps;

localparam int frame_cycles = int'(`PRC_FRAME_LINES) * `PRC_LINE_CYCLES;
localparam int rate_frames  = 12;   // lock-on plus one period for each of two rate settings
localparam int draw_frames  = 3;    // wait for the active frame, render, end of frame
localparam int watchdog_cycles = (rate_frames + 3 * draw_frames + 2) * frame_cycles;

logic        clk = 1'b0;
logic        reset;
logic        bus_write;
logic [23:0] bus_address_in;
logic [7:0]  bus_data_in;
logic [7:0]  host_data;
logic [7:0]  bus_data_out;
logic [23:0] bus_address_out;
logic        write;
logic        read;
logic        bus_request;
logic        bus_ack = 1'b0;
logic        irq_copy_complete;
logic        irq_render_done;

logic [7:0]  mem [0:65535];     // 64 KiB system memory
logic [7:0]  mem_rdata = 8'h00;
logic        mem_valid = 1'b0;
logic [8:0]  lcd_q [$];         // {data port, byte} per LCD write
logic [7:0]  exp_vram [0:767];
logic        drop_ack;          // random bus_ack drops for back-pressure
int          cycle = 0;
int          copy_irqs = 0;
int          stall_cycles = 0;

always #50 clk = ~clk;

// memory drives the data bus in the cycle after a read strobe
assign bus_data_in = mem_valid ? mem_rdata : host_data;

prc dut_i
(
    .clk               (clk),
    .reset             (reset),
    .bus_write         (bus_write),
    .bus_address_in    (bus_address_in),
    .bus_data_in       (bus_data_in),
    .bus_data_out      (bus_data_out),
    .bus_address_out   (bus_address_out),
    .write             (write),
    .read              (read),
    .bus_request       (bus_request),
    .bus_ack           (bus_ack),
    .irq_copy_complete (irq_copy_complete),
    .irq_render_done   (irq_render_done)
);

// memory model with LCD port logging
always @(posedge clk)
begin
    mem_valid <= read;
    if (read)
        mem_rdata <= mem[bus_address_out[15:0]];
    if (write)
    begin
        mem[bus_address_out[15:0]] = bus_data_out;
        if (bus_address_out == `PRC_LCD_CMD || bus_address_out == `PRC_LCD_DATA)
            lcd_q.push_back({bus_address_out == `PRC_LCD_DATA, bus_data_out});
    end
end

// bus grant follows the request and drops a third of the cycles under back-pressure
always @(posedge clk)
begin
    if (drop_ack)
        bus_ack <= bus_request && ($urandom % 3 != 0);
    else
        bus_ack <= bus_request;
end

always @(posedge clk)
begin
    cycle <= cycle + 1;
    if (irq_copy_complete)
        copy_irqs <= copy_irqs + 1;
    if (bus_request && !bus_ack)
        stall_cycles <= stall_cycles + 1;
    if ((read || write) && !bus_ack)
    begin
        $display("read or write strobe at cycle %0d while bus_ack was low", cycle);
        $display("Simulation failed");
        $fatal(1, "bus strobe without grant");
    end
end

initial
begin
    repeat (watchdog_cycles) @(posedge clk);
    $display("watchdog expired after %0d cycles, a test did not finish", watchdog_cycles);
    $display("Simulation failed");
    $fatal(1, "timeout");
end

`include "prc_tb_tasks.svh"

initial
begin
    reset          = 1'b1;
    bus_write      = 1'b0;
    bus_address_in = 24'h000000;
    host_data      = 8'h00;
    drop_ack       = 1'b0;
    void'($urandom(87));
    repeat (8) @(posedge clk);
    reset <= 1'b0;
    repeat (2) @(posedge clk);

    register_access();
    scroll_limits();
    render_rate(3'd4);
    render_rate(3'd0);
    frame_copy_only();
    map_draw_and_copy("map_draw", 1'b0);
    map_draw_and_copy("back_pressure", 1'b1);

    $display("Simulation completed successfully");
    $finish;
end

endmodule

// ==== prc.sv ====
module prc
(
    input  logic        clk,
    input  logic        reset,
    input  logic        bus_write,
    input  logic [23:0] bus_address_in,
    input  logic [7:0]  bus_data_in,
    output logic [7:0]  bus_data_out,
    output logic [23:0] bus_address_out,
    output logic        write,
    output logic        read,
    output logic        bus_request,
    input  logic        bus_ack,
    output logic        irq_copy_complete,
    output logic        irq_render_done
);

prc_pkg::prc_regs_t   regs;
prc_pkg::bus_access_t map_req;
prc_pkg::bus_access_t copy_req;
logic [7:0]           reg_rd_data;
logic [7:0]           wr_data;
logic [7:0]           rd_data;
logic [6:0]           line_count;
logic [3:0]           frame_count;
logic                 draw_start;
logic                 draw_window;
logic                 map_start;
logic                 copy_start;
logic                 map_done;
logic                 copy_done;
logic                 acc_done;

// write data while mastering the bus, register readback otherwise
assign bus_data_out = bus_ack ? wr_data : reg_rd_data;

prc_regs u_regs
(
    .clk            (clk),
    .reset          (reset),
    .bus_write      (bus_write),
    .bus_address_in (bus_address_in),
    .bus_data_in    (bus_data_in),
    .line_count     (line_count),
    .frame_count    (frame_count),
    .regs           (regs),
    .reg_rd_data    (reg_rd_data)
);

prc_frame_timer u_frame_timer
(
    .clk             (clk),
    .reset           (reset),
    .regs            (regs),
    .line_count      (line_count),
    .frame_count     (frame_count),
    .draw_start      (draw_start),
    .draw_window     (draw_window),
    .irq_render_done (irq_render_done)
);

prc_stage_ctrl u_stage_ctrl
(
    .clk               (clk),
    .reset             (reset),
    .regs              (regs),
    .draw_start        (draw_start),
    .draw_window       (draw_window),
    .bus_ack           (bus_ack),
    .bus_data_in       (bus_data_in),
    .map_req           (map_req),
    .copy_req          (copy_req),
    .map_done          (map_done),
    .copy_done         (copy_done),
    .map_start         (map_start),
    .copy_start        (copy_start),
    .acc_done          (acc_done),
    .rd_data           (rd_data),
    .bus_request       (bus_request),
    .read              (read),
    .write             (write),
    .bus_address_out   (bus_address_out),
    .wr_data           (wr_data),
    .irq_copy_complete (irq_copy_complete)
);

prc_map_draw u_map_draw
(
    .clk      (clk),
    .reset    (reset),
    .start    (map_start),
    .regs     (regs),
    .acc_done (acc_done),
    .rd_data  (rd_data),
    .req      (map_req),
    .done     (map_done)
);

prc_frame_copy u_frame_copy
(
    .clk      (clk),
    .reset    (reset),
    .start    (copy_start),
    .acc_done (acc_done),
    .rd_data  (rd_data),
    .req      (copy_req),
    .done     (copy_done)
);

endmodule

// ==== prc_frame_copy.sv ====
`include "prc_defines.svh"

module prc_frame_copy
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 start,
    input  logic                 acc_done,
    input  logic [7:0]           rd_data,
    output prc_pkg::bus_access_t req,
    output logic                 done
);

typedef enum logic [2:0]
{
    CP_COL_HI,      // column address high nibble
    CP_COL_LO,
    CP_PAGE,
    CP_READ,
    CP_WRITE
} copy_state_t;

copy_state_t state;
logic        busy;
logic [2:0]  page;
logic [6:0]  col;
logic [7:0]  pixel;

always_comb
begin
    req.cmd   = busy ? prc_pkg::BUS_WRITE : prc_pkg::BUS_IDLE;
    req.addr  = `PRC_LCD_CMD;
    req.wdata = pixel;
    case (state)
        CP_COL_HI: req.wdata = 8'h10;
        CP_COL_LO: req.wdata = 8'h00;
        CP_PAGE:   req.wdata = {5'b10110, page};    // 0xB0 + page
        CP_READ:
        begin
            req.cmd  = busy ? prc_pkg::BUS_READ : prc_pkg::BUS_IDLE;
            req.addr = `PRC_VRAM_BASE + 24'(page) * 24'(`PRC_SCREEN_COLS) + 24'(col);
        end
        default:   req.addr = `PRC_LCD_DATA;
    endcase
end

always_ff @(posedge clk, posedge reset)
begin
    if (reset)
    begin
        state <= CP_COL_HI;
        busy  <= 1'b0;
        page  <= '0;
        col   <= '0;
        done  <= 1'b0;
    end
    else
    begin
        done <= 1'b0;
        if (start)
        begin
            state <= CP_COL_HI;
            busy  <= 1'b1;
            page  <= '0;
            col   <= '0;
        end
        else if (busy && acc_done)
        begin
            case (state)
                CP_COL_HI: state <= CP_COL_LO;
                CP_COL_LO: state <= CP_PAGE;
                CP_PAGE:   state <= CP_READ;
                CP_READ:   state <= CP_WRITE;
                default:
                begin
                    state <= CP_READ;
                    col   <= col + 7'd1;
                    if (col == 7'(`PRC_SCREEN_COLS - 1))
                    begin
                        state <= CP_COL_HI;     // next page starts with its commands
                        col   <= '0;
                        page  <= page + 3'd1;
                        busy  <= page != 3'(`PRC_PAGES - 1);
                        done  <= page == 3'(`PRC_PAGES - 1);
                    end
                end
            endcase
        end
    end
end

always_ff @(posedge clk)
begin
    if (busy && acc_done && state == CP_READ)
        pixel <= rd_data;
end

endmodule

// ==== prc_map_draw.sv ====
`include "prc_defines.svh"

module prc_map_draw
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 start,
    input  prc_pkg::prc_regs_t   regs,
    input  logic                 acc_done,
    input  logic [7:0]           rd_data,
    output prc_pkg::bus_access_t req,
    output logic                 done
);

logic       busy;
logic [2:0] page;
logic [6:0] col;
logic [1:0] step;       // 0 tile index, 1 tile byte, 2 vram write
logic [7:0] tile_idx;
logic [7:0] tile_byte;
logic [7:0] map_x;      // pixel position inside the map
logic [7:0] map_y;

assign map_x = {1'b0, col} + {1'b0, regs.scroll_x};
assign map_y = {2'b00, page, 3'b000} + {1'b0, regs.scroll_y};

always_comb
begin
    req.cmd   = !busy ? prc_pkg::BUS_IDLE :
                (step == 2'd2) ? prc_pkg::BUS_WRITE : prc_pkg::BUS_READ;
    req.wdata = tile_byte >> map_y[2:0];
    case (step)
        2'd0:
            req.addr = `PRC_TILEMAP_BASE + 24'(map_y[7:3]) * 24'(regs.map_width) +
                       24'(map_x[7:3]);
        2'd1:
            req.addr = regs.map_base + {13'd0, tile_idx, map_x[2:0]};
        default:
            req.addr = `PRC_VRAM_BASE + 24'(page) * 24'(`PRC_SCREEN_COLS) + 24'(col);
    endcase
end

always_ff @(posedge clk, posedge reset)
begin
    if (reset)
    begin
        busy <= 1'b0;
        page <= '0;
        col  <= '0;
        step <= '0;
        done <= 1'b0;
    end
    else
    begin
        done <= 1'b0;
        if (start)
        begin
            busy <= 1'b1;
            page <= '0;
            col  <= '0;
            step <= '0;
        end
        else if (busy && acc_done)
        begin
            step <= (step == 2'd2) ? 2'd0 : step + 2'd1;
            if (step == 2'd2)
            begin
                col <= col + 7'd1;
                if (col == 7'(`PRC_SCREEN_COLS - 1))
                begin
                    col  <= '0;
                    page <= page + 3'd1;
                    if (page == 3'(`PRC_PAGES - 1))
                    begin
                        busy <= 1'b0;
                        done <= 1'b1;     // last column of last page written
                    end
                end
            end
        end
    end
end

always_ff @(posedge clk)
begin
    if (busy && acc_done && step == 2'd0)
        tile_idx <= rd_data;
    if (busy && acc_done && step == 2'd1)
        tile_byte <= rd_data;
end

endmodule

// ==== prc_stage_ctrl.sv ====
module prc_stage_ctrl
(
    input  logic                 clk,
    input  logic                 reset,
    input  prc_pkg::prc_regs_t   regs,
    input  logic                 draw_start,
    input  logic                 draw_window,
    input  logic                 bus_ack,
    input  logic [7:0]           bus_data_in,
    input  prc_pkg::bus_access_t map_req,
    input  prc_pkg::bus_access_t copy_req,
    input  logic                 map_done,
    input  logic                 copy_done,
    output logic                 map_start,
    output logic                 copy_start,
    output logic                 acc_done,
    output logic [7:0]           rd_data,
    output logic                 bus_request,
    output logic                 read,
    output logic                 write,
    output logic [23:0]          bus_address_out,
    output logic [7:0]           wr_data,
    output logic                 irq_copy_complete
);

prc_pkg::stage_t      stage;
prc_pkg::bus_access_t cur_req;     // request of the active engine
prc_pkg::bus_access_t acc;         // access in flight
logic [1:0]           phase;       // 0 issue, 1 strobe, 2 data back

always_comb
begin
    case (stage)
        prc_pkg::STAGE_MAP_DRAW:   cur_req = map_req;
        prc_pkg::STAGE_FRAME_COPY: cur_req = copy_req;
        default:                   cur_req = '0;
    endcase
end

// stage order is map draw, then frame copy
always_ff @(posedge clk, posedge reset)
begin
    if (reset)
    begin
        stage             <= prc_pkg::STAGE_IDLE;
        map_start         <= 1'b0;
        copy_start        <= 1'b0;
        irq_copy_complete <= 1'b0;
    end
    else
    begin
        map_start         <= 1'b0;
        copy_start        <= 1'b0;
        irq_copy_complete <= 1'b0;
        case (stage)
            prc_pkg::STAGE_IDLE:
                if (draw_start && regs.mode[1])
                begin
                    stage     <= prc_pkg::STAGE_MAP_DRAW;
                    map_start <= 1'b1;
                end
                else if (draw_start && regs.mode[3])
                begin
                    stage      <= prc_pkg::STAGE_FRAME_COPY;
                    copy_start <= 1'b1;
                end
            prc_pkg::STAGE_MAP_DRAW:
                if (map_done && regs.mode[3])
                begin
                    stage      <= prc_pkg::STAGE_FRAME_COPY;
                    copy_start <= 1'b1;
                end
                else if (map_done)
                    stage <= prc_pkg::STAGE_IDLE;
            prc_pkg::STAGE_FRAME_COPY:
                if (copy_done)
                begin
                    stage             <= prc_pkg::STAGE_IDLE;
                    irq_copy_complete <= 1'b1;
                end
            default: stage <= prc_pkg::STAGE_IDLE;
        endcase
    end
end

// one access at a time and the strobe waits for bus_ack
always_ff @(posedge clk, posedge reset)
begin
    if (reset)
    begin
        phase <= 2'd0;
        acc   <= '0;
    end
    else
    begin
        case (phase)
            2'd0:
                if (bus_ack && cur_req.cmd != prc_pkg::BUS_IDLE)
                begin
                    acc   <= cur_req;
                    phase <= 2'd1;
                end
            2'd1:    if (bus_ack) phase <= 2'd2;
            default: phase <= 2'd0;
        endcase
    end
end

assign read            = phase == 2'd1 && bus_ack && acc.cmd == prc_pkg::BUS_READ;
assign write           = phase == 2'd1 && bus_ack && acc.cmd == prc_pkg::BUS_WRITE;
assign acc_done        = phase == 2'd2;
assign rd_data         = bus_data_in;      // memory answers in the cycle after the strobe
assign bus_address_out = acc.addr;
assign wr_data         = acc.wdata;
assign bus_request     = draw_window;

a_one_strobe: assert property (@(posedge clk) disable iff (reset) !(read && write));

endmodule

// ==== prc_frame_timer.sv ====
`include "prc_defines.svh"

module prc_frame_timer
(
    input  logic               clk,
    input  logic               reset,
    input  prc_pkg::prc_regs_t regs,
    output logic [6:0]         line_count,
    output logic [3:0]         frame_count,
    output logic               draw_start,
    output logic               draw_window,
    output logic               irq_render_done
);

logic [9:0] osc_count;
logic [3:0] rate_match;
logic [2:0] sel_q;          // detects a rate change
logic       line_end;
logic       last_line;
logic       frame_active;

always_comb
begin
    case (regs.rate_match_sel)
        3'd0:    rate_match = 4'd2;    // /3
        3'd1:    rate_match = 4'd5;    // /6
        3'd2:    rate_match = 4'd8;    // /9
        3'd3:    rate_match = 4'd11;   // /12
        3'd4:    rate_match = 4'd1;    // /2
        3'd5:    rate_match = 4'd3;    // /4
        3'd6:    rate_match = 4'd5;    // /6
        default: rate_match = 4'd7;    // /8
    endcase
end

assign line_end     = osc_count == 10'(`PRC_LINE_CYCLES - 1);
assign last_line    = line_count == `PRC_FRAME_LINES;
assign frame_active = frame_count == rate_match;

always_ff @(posedge clk, posedge reset)
begin
    if (reset)
    begin
        osc_count       <= '0;
        line_count      <= 7'd1;
        frame_count     <= '0;
        sel_q           <= '0;
        draw_start      <= 1'b0;
        draw_window     <= 1'b0;
        irq_render_done <= 1'b0;
    end
    else
    begin
        draw_start      <= 1'b0;
        irq_render_done <= 1'b0;
        sel_q           <= regs.rate_match_sel;
        osc_count       <= line_end ? 10'd0 : osc_count + 10'd1;

        if (line_end)
        begin
            line_count <= last_line ? 7'd1 : line_count + 7'd1;

            // next line opens the draw window
            if (frame_active && line_count == `PRC_DRAW_START_LINE - 7'd1 &&
                (regs.mode[1] || regs.mode[3]))
            begin
                draw_start  <= 1'b1;
                draw_window <= 1'b1;
            end

            if (last_line)
            begin
                draw_window <= 1'b0;
                if (frame_active)
                begin
                    frame_count     <= '0;
                    irq_render_done <= 1'b1;
                end
                else
                    frame_count <= frame_count + 4'd1;
            end
        end

        if (sel_q != regs.rate_match_sel)
            frame_count <= '0;     // new rate counts from scratch
    end
end

a_start_line: assert property (@(posedge clk) disable iff (reset)
    draw_start |-> line_count == `PRC_DRAW_START_LINE);

endmodule

// ==== prc_regs.sv ====
`include "prc_defines.svh"

module prc_regs
(
    input  logic               clk,
    input  logic               reset,
    input  logic               bus_write,
    input  logic [23:0]        bus_address_in,
    input  logic [7:0]         bus_data_in,
    input  logic [6:0]         line_count,
    input  logic [3:0]         frame_count,
    output prc_pkg::prc_regs_t regs,
    output logic [7:0]         reg_rd_data
);

logic [5:0]  mode;
logic [2:0]  rate_sel;
logic        rate_lsb;      // reads back as written with no function
logic [23:0] map_base;
logic [23:0] sprite_base;
logic [6:0]  scroll_x;
logic [6:0]  scroll_y;
logic [4:0]  map_width;
logic [4:0]  map_height;
logic [7:0]  scroll_x_max;
logic [7:0]  scroll_y_max;

// map size in tiles
always_comb
begin
    case (mode[5:4])
        2'd0:    {map_width, map_height} = {5'd12, 5'd16};
        2'd1:    {map_width, map_height} = {5'd16, 5'd12};
        2'd2:    {map_width, map_height} = {5'd24, 5'd8};
        default: {map_width, map_height} = {5'd24, 5'd16};
    endcase
end

// largest scroll that keeps the screen inside the map
assign scroll_x_max = {map_width, 3'b000} - 8'd96;
assign scroll_y_max = {map_height, 3'b000} - 8'd64;

always_ff @(posedge clk, posedge reset)
begin
    if (reset)
    begin
        mode        <= '0;
        rate_sel    <= '0;
        rate_lsb    <= 1'b0;
        map_base    <= '0;
        sprite_base <= '0;
        scroll_x    <= '0;
        scroll_y    <= '0;
    end
    else if (bus_write)
    begin
        case (bus_address_in)
            `PRC_REG_MODE:    mode <= bus_data_in[5:0];
            `PRC_REG_RATE:
            begin
                rate_sel <= bus_data_in[3:1];
                rate_lsb <= bus_data_in[0];
            end
            `PRC_REG_MAP_LO:  map_base[7:3]      <= bus_data_in[7:3];  // 8 byte aligned
            `PRC_REG_MAP_MID: map_base[15:8]     <= bus_data_in;
            `PRC_REG_MAP_HI:  map_base[20:16]    <= bus_data_in[4:0];
            `PRC_REG_SCROLL_Y:
                if ({1'b0, bus_data_in[6:0]} <= scroll_y_max)
                    scroll_y <= bus_data_in[6:0];
            `PRC_REG_SCROLL_X:
                if ({1'b0, bus_data_in[6:0]} <= scroll_x_max)
                    scroll_x <= bus_data_in[6:0];
            `PRC_REG_SPR_LO:  sprite_base[7:6]   <= bus_data_in[7:6];
            `PRC_REG_SPR_MID: sprite_base[15:8]  <= bus_data_in;
            `PRC_REG_SPR_HI:  sprite_base[20:16] <= bus_data_in[4:0];
            default:
            begin
            end
        endcase
    end
end

always_comb
begin
    regs.mode           = mode;
    regs.rate_match_sel = rate_sel;
    regs.map_base       = map_base;
    regs.sprite_base    = sprite_base;
    regs.scroll_x       = scroll_x;
    regs.scroll_y       = scroll_y;
    regs.map_width      = map_width;
    regs.map_height     = map_height;
end

// readback
always_comb
begin
    case (bus_address_in)
        `PRC_REG_MODE:     reg_rd_data = {2'b00, mode};
        `PRC_REG_RATE:     reg_rd_data = {frame_count, rate_sel, rate_lsb};
        `PRC_REG_MAP_LO:   reg_rd_data = map_base[7:0];
        `PRC_REG_MAP_MID:  reg_rd_data = map_base[15:8];
        `PRC_REG_MAP_HI:   reg_rd_data = map_base[23:16];
        `PRC_REG_SCROLL_Y: reg_rd_data = {1'b0, scroll_y};
        `PRC_REG_SCROLL_X: reg_rd_data = {1'b0, scroll_x};
        `PRC_REG_SPR_LO:   reg_rd_data = sprite_base[7:0];
        `PRC_REG_SPR_MID:  reg_rd_data = sprite_base[15:8];
        `PRC_REG_SPR_HI:   reg_rd_data = sprite_base[23:16];
        `PRC_REG_COUNTER:  reg_rd_data = {1'b0, line_count};
        default:           reg_rd_data = 8'h00;
    endcase
end

a_regs_known: assert property (@(posedge clk) disable iff (reset) !$isunknown(regs));

endmodule

// ==== prc_pkg.sv ====
package prc_pkg;

    typedef enum logic [1:0]
    {
        BUS_IDLE  = 2'd0,
        BUS_READ  = 2'd1,
        BUS_WRITE = 2'd2
    } bus_cmd_t;

    // one access as an engine asks for it
    typedef struct packed
    {
        bus_cmd_t    cmd;
        logic [23:0] addr;
        logic [7:0]  wdata;     // ignored for reads
    } bus_access_t;

    typedef struct packed
    {
        logic [5:0]  mode;            // bit 1 map draw, bit 3 frame copy
        logic [2:0]  rate_match_sel;
        logic [23:0] map_base;
        logic [23:0] sprite_base;     // readback only
        logic [6:0]  scroll_x;
        logic [6:0]  scroll_y;
        logic [4:0]  map_width;       // in tiles, from mode[5:4]
        logic [4:0]  map_height;
    } prc_regs_t;

    typedef enum logic [1:0]
    {
        STAGE_IDLE       = 2'd0,
        STAGE_MAP_DRAW   = 2'd1,
        STAGE_FRAME_COPY = 2'd2
    } stage_t;

endpackage

// ==== prc_defines.svh ====
`ifndef PRC_DEFINES_SVH
`define PRC_DEFINES_SVH

// register map
`define PRC_REG_MODE        24'h2080
`define PRC_REG_RATE        24'h2081
`define PRC_REG_MAP_LO      24'h2082
`define PRC_REG_MAP_MID     24'h2083
`define PRC_REG_MAP_HI      24'h2084
`define PRC_REG_SCROLL_Y    24'h2085
`define PRC_REG_SCROLL_X    24'h2086
`define PRC_REG_SPR_LO      24'h2087
`define PRC_REG_SPR_MID     24'h2088
`define PRC_REG_SPR_HI      24'h2089
`define PRC_REG_COUNTER     24'h208A

// memory map
`define PRC_VRAM_BASE       24'h001000
`define PRC_TILEMAP_BASE    24'h001360
`define PRC_LCD_CMD         24'h0020FE
`define PRC_LCD_DATA        24'h0020FF

// one page is 8 pixel rows
`define PRC_SCREEN_COLS     96
`define PRC_PAGES           8

// line timing
`define PRC_LINE_CYCLES     855
`define PRC_DRAW_START_LINE 7'h18
`define PRC_FRAME_LINES     7'h42

`endif
